/* Makefile */
VERILATOR  ?= verilator
TOP        := adiv_tb
FILELIST   := adiv.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* adiv.f */
source/adiv_pkg.sv
source/adiv_if.sv
source/adiv_decode.sv
source/adiv_array.sv
source/adiv_result.sv
source/adiv_top.sv
testbench/adiv_sva.sv
testbench/adiv_tb.sv

/* source/adiv_array.sv */
`default_nettype none

module adiv_array (
  input  logic         clk,
  input  logic         rst_n,
  adiv_op_if.execute   op,
  adiv_res_if.execute  res
);

  // row i produces quotient bit i, column j lines up with divisor bit j
  logic [adiv_pkg::d_width-1:0] rem  [adiv_pkg::d_width];  // restored remainder bits
  logic [adiv_pkg::d_width-1:0] bout [adiv_pkg::d_width];  // borrow chain per row
  logic [adiv_pkg::d_width-1:0] q;

  for (genvar i = 0; i < adiv_pkg::d_width; i++) begin : g_row
    logic top_bit;  // bit left of the row's msb cell

    if (i == adiv_pkg::d_width - 1) begin : g_top_dvd
      assign top_bit = op.dividend[adiv_pkg::n_width-1];
    end else begin : g_top_rem
      assign top_bit = rem[i + 1][adiv_pkg::d_width-1];
    end

    // row subtraction succeeds unless it borrows out
    assign q[i] = top_bit | ~bout[i][adiv_pkg::d_width-1];

    for (genvar j = 0; j < adiv_pkg::d_width; j++) begin : g_col
      logic x;
      logic y;
      logic b_in;
      logic use_approx;
      logic diff;
      logic b_out;

      if (j == 0) begin : g_lsb
        assign x    = op.dividend[i];  // fresh dividend bit enters each row
        assign b_in = 1'b0;
      end else if (i == adiv_pkg::d_width - 1) begin : g_first
        assign x    = op.dividend[i + j];  // first row sees dividend only
        assign b_in = bout[i][j - 1];
      end else begin : g_inner
        assign x    = rem[i + 1][j - 1];
        assign b_in = bout[i][j - 1];
      end

      assign y          = op.divisor[j];
      assign use_approx = op.approx && ((i + j) < adiv_pkg::approx_depth);

      always_comb begin
        if (use_approx) begin
          diff  = x & ~y;
          b_out = y & (~x | b_in);
        end else begin
          diff  = x ^ y ^ b_in;
          b_out = (~x & y) | (~(x ^ y) & b_in);
        end
      end

      assign bout[i][j] = b_out;
      assign rem[i][j]  = q[i] ? diff : x;  // restore on failed subtract
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= op.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (op.valid) begin
      res.quotient  <= q;
      res.remainder <= rem[0];
      res.status    <= op.status;  // screened upstream, passed through
    end
  end

endmodule

`default_nettype wire

/* source/adiv_decode.sv */
`default_nettype none

module adiv_decode (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  adiv_pkg::opcode_e              opcode,
  input  logic [adiv_pkg::n_width-1:0]   dividend,
  input  logic [adiv_pkg::d_width-1:0]   divisor,
  adiv_op_if.decode                      op
);

  logic              known_op;
  logic              overflow;
  adiv_pkg::status_e status_next;

  assign known_op = (opcode == adiv_pkg::op_div_exact) ||
                    (opcode == adiv_pkg::op_div_approx);

  // quotient needs more than d_width bits
  assign overflow = dividend[adiv_pkg::n_width-1 -: adiv_pkg::d_width] >= divisor;

  always_comb begin
    if (!known_op) begin
      status_next = adiv_pkg::st_bad_op;  // wins even over a zero divisor
    end else if (divisor == '0) begin
      status_next = adiv_pkg::st_div_zero;
    end else if (overflow) begin
      status_next = adiv_pkg::st_overflow;
    end else begin
      status_next = adiv_pkg::st_ok;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op.valid <= 1'b0;
    end else begin
      op.valid <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op.approx   <= (opcode == adiv_pkg::op_div_approx);
      op.dividend <= dividend;
      op.divisor  <= divisor;
      op.status   <= status_next;
    end
  end

endmodule

`default_nettype wire

/* source/adiv_if.sv */
`default_nettype none

interface adiv_op_if;
  logic                           valid;
  logic                           approx;
  logic [adiv_pkg::n_width-1:0]   dividend;
  logic [adiv_pkg::d_width-1:0]   divisor;
  adiv_pkg::status_e              status;

  modport decode  (output valid, approx, dividend, divisor, status);
  modport execute (input  valid, approx, dividend, divisor, status);
endinterface

interface adiv_res_if;
  logic                           valid;
  logic [adiv_pkg::d_width-1:0]   quotient;   // raw, not yet masked
  logic [adiv_pkg::d_width-1:0]   remainder;
  adiv_pkg::status_e              status;

  modport execute (output valid, quotient, remainder, status);
  modport result  (input  valid, quotient, remainder, status);
endinterface

`default_nettype wire

/* source/adiv_pkg.sv */
`default_nettype none

package adiv_pkg;

  localparam int n_width = 16;  // dividend
  localparam int d_width = 8;   // divisor, quotient, remainder

  // cell (i, j) is approximate when i + j < approx_depth
  localparam int approx_depth = 6;

  // start strobe to done pulse, in cycles
  localparam int latency = 3;

  typedef enum logic [1:0] {
    op_div_exact  = 2'd0,
    op_div_approx = 2'd1,
    op_unused_2   = 2'd2,
    op_unused_3   = 2'd3
  } opcode_e;

  typedef enum logic [1:0] {
    st_ok       = 2'd0,
    st_div_zero = 2'd1,
    st_overflow = 2'd2,
    st_bad_op   = 2'd3
  } status_e;

endpackage

`default_nettype wire

/* source/adiv_result.sv */
`default_nettype none

module adiv_result (
  input  logic                           clk,
  input  logic                           rst_n,
  adiv_res_if.result                     res,
  output logic                           done,
  output logic [adiv_pkg::d_width-1:0]   quotient,
  output logic [adiv_pkg::d_width-1:0]   remainder,
  output adiv_pkg::status_e              status
);

  logic ok;

  assign ok = (res.status == adiv_pkg::st_ok);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= res.valid;  // single-cycle pulse per result
    end
  end

  // outputs hold until the next result arrives
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      quotient  <= '0;
      remainder <= '0;
      status    <= adiv_pkg::st_ok;
    end else if (res.valid) begin
      status <= res.status;
      if (ok) begin
        quotient  <= res.quotient;
        remainder <= res.remainder;
      end else begin
        quotient  <= '0;  // failed commands give no data
        remainder <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/adiv_top.sv */
`default_nettype none

module adiv_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  adiv_pkg::opcode_e              opcode,
  input  logic [adiv_pkg::n_width-1:0]   dividend,
  input  logic [adiv_pkg::d_width-1:0]   divisor,
  output logic                           done,
  output logic [adiv_pkg::d_width-1:0]   quotient,
  output logic [adiv_pkg::d_width-1:0]   remainder,
  output adiv_pkg::status_e              status
);

  adiv_op_if  op_bus ();
  adiv_res_if res_bus ();

  adiv_decode decode_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .opcode   (opcode),
    .dividend (dividend),
    .divisor  (divisor),
    .op       (op_bus)
  );

  adiv_array array_i (
    .clk   (clk),
    .rst_n (rst_n),
    .op    (op_bus),
    .res   (res_bus)
  );

  adiv_result result_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .res       (res_bus),
    .done      (done),
    .quotient  (quotient),
    .remainder (remainder),
    .status    (status)
  );

endmodule

`default_nettype wire

/* testbench/adiv_sva.sv */
`default_nettype none

module adiv_sva (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           start,
  input logic                           done,
  input logic [adiv_pkg::d_width-1:0]   quotient,
  input logic [adiv_pkg::d_width-1:0]   remainder,
  input adiv_pkg::status_e              status
);
  timeunit 1ns;
  timeprecision 100ps;

  // fixed pipeline depth, no stalls
  done_latency: assert property (@(posedge clk) disable iff (!rst_n)
    done == $past(start, adiv_pkg::latency))
    else $error("done does not follow start by the pipeline latency");

  done_in_reset: assert property (@(posedge clk) !rst_n |-> !done)
    else $error("done high while reset is asserted");

  masked_on_error: assert property (@(posedge clk) disable iff (!rst_n)
    (done && status != adiv_pkg::st_ok) |-> (quotient == '0 && remainder == '0))
    else $error("failed command returned nonzero quotient or remainder");

endmodule

bind adiv_top adiv_sva sva_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .start     (start),
  .done      (done),
  .quotient  (quotient),
  .remainder (remainder),
  .status    (status)
);

`default_nettype wire

/* testbench/adiv_tb.sv */
`default_nettype none

module adiv_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_tests    = 400;
  localparam int max_cycles = n_tests * 4 + 20;

  logic                         clk;
  logic                         rst_n;
  logic                         start;
  adiv_pkg::opcode_e            opcode;
  logic [adiv_pkg::n_width-1:0] dividend;
  logic [adiv_pkg::d_width-1:0] divisor;
  logic                         done;
  logic [adiv_pkg::d_width-1:0] quotient;
  logic [adiv_pkg::d_width-1:0] remainder;
  adiv_pkg::status_e            status;

  logic [31:0] rng_state = 32'he1b0;
  int          cycle     = 0;
  int          issued    = 0;

  // one entry per command in flight
  string                        name_q[$];
  int                           due_q[$];
  adiv_pkg::status_e            exp_status_q[$];
  logic [adiv_pkg::d_width-1:0] exp_quot_q[$];
  logic [adiv_pkg::d_width-1:0] exp_rem_q[$];

  adiv_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .opcode    (opcode),
    .dividend  (dividend),
    .divisor   (divisor),
    .done      (done),
    .quotient  (quotient),
    .remainder (remainder),
    .status    (status)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // restoring array, low triangle uses the simplified cell
  function automatic void approx_divide(input logic [adiv_pkg::n_width-1:0] n,
                                        input logic [adiv_pkg::d_width-1:0] d,
                                        output logic [adiv_pkg::d_width-1:0] q,
                                        output logic [adiv_pkg::d_width-1:0] r);
    logic [adiv_pkg::d_width-1:0] part;
    logic [adiv_pkg::d_width-1:0] x;
    logic [adiv_pkg::d_width-1:0] diff;
    logic                         b;
    logic                         top;
    part = n[adiv_pkg::n_width-1 -: adiv_pkg::d_width];
    for (int i = adiv_pkg::d_width - 1; i >= 0; i--) begin
      x   = {part[adiv_pkg::d_width-2:0], n[i]};
      top = part[adiv_pkg::d_width-1];
      b   = 1'b0;
      for (int j = 0; j < adiv_pkg::d_width; j++) begin
        if ((i + j) < adiv_pkg::approx_depth) begin
          diff[j] = x[j] & ~d[j];
          b       = d[j] & (~x[j] | b);
        end else begin
          diff[j] = x[j] ^ d[j] ^ b;
          b       = (~x[j] & d[j]) | (~(x[j] ^ d[j]) & b);
        end
      end
      q[i] = top | ~b;
      part = q[i] ? diff : x;
    end
    r = part;
  endfunction

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_status(input string name, input adiv_pkg::status_e expected,
                              input adiv_pkg::status_e actual);
    if (actual !== expected) begin
      $display("error %s status: expected %s, actual %s", name, expected.name(), actual.name());
      stop_with_failure();
    end
  endtask

  task automatic check_quotient(input string name, input logic [adiv_pkg::d_width-1:0] expected,
                                input logic [adiv_pkg::d_width-1:0] actual);
    if (actual !== expected) begin
      $display("error %s quotient: expected %0d, actual %0d", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_remainder(input string name, input logic [adiv_pkg::d_width-1:0] expected,
                                 input logic [adiv_pkg::d_width-1:0] actual);
    if (actual !== expected) begin
      $display("error %s remainder: expected %0d, actual %0d", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic issue_command(input logic [31:0] r1, input logic [31:0] r2);
    adiv_pkg::opcode_e            op;
    adiv_pkg::status_e            st;
    logic [adiv_pkg::d_width-1:0] dv;
    logic [adiv_pkg::d_width-1:0] upper;
    logic [adiv_pkg::n_width-1:0] dd;
    logic [adiv_pkg::d_width-1:0] q;
    logic [adiv_pkg::d_width-1:0] r;
    string                        kind;
    if (r1[3:0] < 4'd6) op = adiv_pkg::op_div_exact;
    else if (r1[3:0] < 4'd13) op = adiv_pkg::op_div_approx;
    else op = r1[4] ? adiv_pkg::op_unused_2 : adiv_pkg::op_unused_3;
    case (r1[7:5])
      3'd0:       dv = '0;
      3'd1, 3'd2: dv = 8'(r1[9:8]) % 8'd3 + 8'd1;  // 1 to 3
      default:    dv = r2[7:0];
    endcase
    if (r1[12:10] != 3'd0 && dv != '0) upper = r2[15:8] % dv;
    else upper = r2[15:8];  // often overflows
    dd = {upper, r2[23:16]};
    q  = '0;
    r  = '0;
    if (op != adiv_pkg::op_div_exact && op != adiv_pkg::op_div_approx) begin
      st   = adiv_pkg::st_bad_op;
      kind = "bad_op";
    end else if (dv == '0) begin
      st   = adiv_pkg::st_div_zero;
      kind = "div_zero";
    end else if (upper >= dv) begin
      st   = adiv_pkg::st_overflow;
      kind = "overflow";
    end else if (op == adiv_pkg::op_div_exact) begin
      st   = adiv_pkg::st_ok;
      q    = 8'(dd / dv);
      r    = 8'(dd % dv);
      kind = "exact";
    end else begin
      st = adiv_pkg::st_ok;
      approx_divide(dd, dv, q, r);
      kind = "approx";
    end
    start    <= 1'b1;
    opcode   <= op;
    dividend <= dd;
    divisor  <= dv;
    name_q.push_back($sformatf("cmd%0d_%s", issued, kind));
    due_q.push_back(cycle + 1 + adiv_pkg::latency);  // sampled one edge from now
    exp_status_q.push_back(st);
    exp_quot_q.push_back(q);
    exp_rem_q.push_back(r);
    issued++;
  endtask

  task automatic check_result();
    string name;
    int    due;
    if (name_q.size() == 0) begin
      $display("done pulse seen with no command outstanding");
      stop_with_failure();
    end
    name = name_q.pop_front();
    due  = due_q.pop_front();
    if (cycle != due) begin
      $display("error %s latency: expected cycle %0d, actual cycle %0d", name, due, cycle);
      stop_with_failure();
    end
    check_status(name, exp_status_q.pop_front(), status);
    check_quotient(name, exp_quot_q.pop_front(), quotient);
    check_remainder(name, exp_rem_q.pop_front(), remainder);
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      $display("timeout after %0d cycles with %0d results pending", cycle, name_q.size());
      stop_with_failure();
    end
    if (rst_n) begin
      if (done) begin
        check_result();
      end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
        $display("%s never produced a done pulse", name_q[0]);
        stop_with_failure();
      end
    end
  end

  initial begin
    logic [31:0] r1;
    logic [31:0] r2;
    rst_n    <= 1'b0;
    start    <= 1'b0;
    opcode   <= adiv_pkg::op_div_exact;
    dividend <= '0;
    divisor  <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    while (issued < n_tests) begin
      @(posedge clk);
      rng_state = xorshift32(rng_state);
      r1        = rng_state;
      rng_state = xorshift32(rng_state);
      r2        = rng_state;
      if (r1[31:29] == 3'd0) begin
        start <= 1'b0;  // occasional bubble
      end else begin
        issue_command(r1, r2);
      end
    end
    @(posedge clk);
    start <= 1'b0;
    while (name_q.size() != 0) @(posedge clk);
    repeat (adiv_pkg::latency + 1) @(posedge clk);  // catch stray done pulses
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
